// File: dbg_unit.f
+incdir+design
design/dbg_pkg.sv
design/dbg_host_port.sv
design/dbg_reg_file.sv
design/dbg_cpu_ctl.sv
design/dbg_mem_seq.sv
design/dbg_unit.sv
verif/dbg_cpu_model.sv
verif/dbg_unit_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = dbg_unit_tb
FILELIST  = dbg_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary -j 0 $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verif/dbg_unit_tb.sv
/*
 * Debug unit testbench
 * Four-phase host transactions against a behavioral CPU,
 * results checked by immediate and concurrent assertions
 */
`timescale 1ns/1ns
`include "dbg_params.svh"

module dbg_unit_tb import dbg_pkg::*; ();

  localparam int        op_count   = 160;  // Host transactions and waits, rounded up
  localparam int        clk_period = 100;
  localparam cpu_id_t   id_value   = 32'h5A3C_1E0F;
  localparam dbg_word_t ctl_rst    = {9'h000, `DBG_CPU_CTL_RST, 3'b000};  // Enables after reset

  logic      dbg_clk, dbg_rst;
  logic      host_req, host_wr, host_ack;
  dbg_addr_t host_addr;
  dbg_word_t host_wdata, host_rdata;
  cpu_id_t   cpu_id;
  logic      dbg_halt_st, cpu_en_s, dbg_en_s, puc_pnd_set, decode_noirq;
  dbg_word_t fe_mdb_in, dbg_mem_din, dbg_reg_din;
  logic      dbg_halt_cmd, dbg_freeze, dbg_cpu_reset, dbg_mem_en, dbg_reg_wr;
  dbg_word_t dbg_mem_addr, dbg_mem_dout;
  mem_wr_t   dbg_mem_wr;

  integer seed = 20990;
  int     errors = 0;
  int     hs_errors = 0;     // Handshake property failures
  int     checks = 0;
  int     passed = 0;
  int     failed = 0;
  int     errs_before;
  int     mem_en_count = 0;  // Cycles with a memory strobe
  string  test_name;

  dbg_unit      dut0 (.*);
  dbg_cpu_model cpu0 (.*);

  initial begin
    dbg_clk = 1'b0;
    forever #(clk_period / 2) dbg_clk = ~dbg_clk;
  end

  initial begin
    #(op_count * 20 * clk_period);
    $display("watchdog: run did not finish within %0d cycles", op_count * 20);
    $display("*** FAILED ***");
    $finish;
  end

  always @(negedge dbg_clk) if (dbg_mem_en) mem_en_count++;

  //////////////////////////////
  // Handshake properties
  //////////////////////////////
  ack_needs_req: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    $rose(host_ack) |-> $past(host_req))
    else begin
      hs_errors++;
      $display("handshake error: ack rose without a request");
    end

  ack_follows_req: assert property (@(posedge dbg_clk) disable iff (dbg_rst)
    $fell(host_req) |=> !host_ack)
    else begin
      hs_errors++;
      $display("handshake error: ack stayed high after the request fell");
    end

  //////////////////////////////
  // Host and check tasks
  //////////////////////////////
  task automatic handshake(output dbg_word_t rdata);
    host_req = 1'b1;
    @(negedge dbg_clk);
    while (!host_ack) @(negedge dbg_clk);
    rdata    = host_rdata;  // Held while ack high
    host_req = 1'b0;
    @(negedge dbg_clk);
    while (host_ack) @(negedge dbg_clk);
  endtask

  task automatic host_write(input dbg_addr_t addr, input dbg_word_t data);
    dbg_word_t unused;
    @(negedge dbg_clk);
    host_addr  = addr;
    host_wdata = data;
    host_wr    = 1'b1;
    handshake(unused);
  endtask

  task automatic host_read(input dbg_addr_t addr, output dbg_word_t data);
    @(negedge dbg_clk);
    host_addr = addr;
    host_wr   = 1'b0;
    handshake(data);
  endtask

  task automatic check_word(input string what, input dbg_word_t exp, input dbg_word_t act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("ERR %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  // Poll MEM_CTL, bit 0 is busy
  task automatic wait_mem_idle();
    dbg_word_t ctl;
    host_read(`DBG_MEM_CTL, ctl);
    while (ctl[0]) host_read(`DBG_MEM_CTL, ctl);
  endtask

  task automatic mem_access(input dbg_word_t ctl);
    host_write(`DBG_MEM_CTL, ctl | (16'h1 << `DBG_MEM_START));
    wait_mem_idle();
  endtask

  task automatic wait_halt_state(input logic level);
    @(negedge dbg_clk);
    while (dbg_halt_st !== level) @(negedge dbg_clk);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    errs_before = errors + hs_errors;
  endtask

  task automatic end_test();
    if (errors + hs_errors == errs_before) begin
      passed++;
      $display("test %-12s ok", test_name);
    end else begin
      failed++;
      $display("test %-12s failed, %0d errors", test_name, errors + hs_errors - errs_before);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    dbg_word_t rd, data, orig, addr;
    logic [7:0] b0, b1;
    int low_cycles, en_before;
    dbg_rst      = 1'b1;
    host_req     = 1'b0;
    host_wr      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    cpu_id       = id_value;
    cpu_en_s     = 1'b1;
    dbg_en_s     = 1'b1;
    puc_pnd_set  = 1'b0;
    decode_noirq = 1'b0;
    fe_mdb_in    = 16'h0000;
    repeat (10) @(posedge dbg_clk);
    @(negedge dbg_clk);
    dbg_rst = 1'b0;

    start_test("reset");
    host_read(`DBG_CPU_ID_LO, rd);
    check_word("CPU_ID_LO", id_value[15:0], rd);
    host_read(`DBG_CPU_ID_HI, rd);
    check_word("CPU_ID_HI", id_value[31:16], rd);
    host_read(`DBG_CPU_CTL, rd);
    check_word("CPU_CTL", ctl_rst, rd);
    check_word("halt_cmd", 16'h0, {15'h0, dbg_halt_cmd});
    check_word("cpu_reset", 16'h0, {15'h0, dbg_cpu_reset});
    end_test();

    start_test("halt_run");
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_HALT));
    check_word("halt_cmd after HALT", 16'h1, {15'h0, dbg_halt_cmd});
    wait_halt_state(1'b1);
    check_word("freeze while halted", 16'h1, {15'h0, dbg_freeze});
    host_read(`DBG_CPU_STAT, rd);
    check_word("CPU_STAT halted", 16'h0001, rd);
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_RUN));
    check_word("halt_cmd after RUN", 16'h0, {15'h0, dbg_halt_cmd});
    wait_halt_state(1'b0);
    end_test();

    start_test("single_step");
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_HALT));
    wait_halt_state(1'b1);
    low_cycles = 0;
    fork
      host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_ISTEP));
      repeat (10) begin
        @(negedge dbg_clk);
        if (!dbg_halt_cmd) low_cycles++;  // Count the release window
      end
    join
    check_word("step release cycles", 16'd2, 16'(low_cycles));
    check_word("halt_cmd after step", 16'h1, {15'h0, dbg_halt_cmd});
    wait_halt_state(1'b1);
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_RUN));
    wait_halt_state(1'b0);
    end_test();

    start_test("sw_break");
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_SW_BRK_EN));
    @(negedge dbg_clk);
    fe_mdb_in    = `DBG_SWBRK_OP;  // Break opcode in decode
    decode_noirq = 1'b1;
    @(negedge dbg_clk);
    fe_mdb_in    = 16'h0000;
    decode_noirq = 1'b0;
    check_word("halt_cmd on break", 16'h1, {15'h0, dbg_halt_cmd});
    wait_halt_state(1'b1);
    host_read(`DBG_CPU_STAT, rd);
    check_word("CPU_STAT break pending", 16'h0001 | (16'h1 << `DBG_STAT_SWBRK_PND), rd);
    host_write(`DBG_CPU_STAT, 16'h1 << `DBG_STAT_SWBRK_PND);
    host_read(`DBG_CPU_STAT, rd);
    check_word("CPU_STAT pending cleared", 16'h0001, rd);
    host_write(`DBG_CPU_CTL, ctl_rst | (16'h1 << `DBG_RUN));
    wait_halt_state(1'b0);
    end_test();

    start_test("mem_word");
    for (int i = 0; i < 4; i++) begin
      addr = {9'h000, 6'($random(seed)), 1'b0};  // Even byte address inside the model
      data = 16'($random(seed));
      host_write(`DBG_MEM_ADDR, addr);
      host_write(`DBG_MEM_DATA, data);
      mem_access(16'h1 << `DBG_MEM_WRITE);
      check_word("model word", data, cpu0.mem[addr[6:1]]);
      host_write(`DBG_MEM_DATA, ~data);           // Stale value, read must replace it
      mem_access(16'h0000);
      check_word("halt_cmd after access", 16'h0, {15'h0, dbg_halt_cmd});
      host_read(`DBG_MEM_DATA, rd);
      check_word("word read back", data, rd);
    end
    host_read(`DBG_CPU_STAT, rd);
    check_word("CPU_STAT running", 16'h0000, rd);
    end_test();

    start_test("mem_byte");
    orig = cpu0.mem[16];
    b1   = 8'($random(seed));
    b0   = 8'($random(seed));
    host_write(`DBG_MEM_ADDR, 16'h0021);
    host_write(`DBG_MEM_DATA, {8'hEE, b1});  // Upper byte ignored
    mem_access((16'h1 << `DBG_MEM_BYTE) | (16'h1 << `DBG_MEM_WRITE));
    check_word("odd byte write", {b1, orig[7:0]}, cpu0.mem[16]);
    host_write(`DBG_MEM_ADDR, 16'h0020);
    host_write(`DBG_MEM_DATA, {8'h11, b0});
    mem_access((16'h1 << `DBG_MEM_BYTE) | (16'h1 << `DBG_MEM_WRITE));
    check_word("even byte write", {b1, b0}, cpu0.mem[16]);
    mem_access(16'h1 << `DBG_MEM_BYTE);
    host_read(`DBG_MEM_DATA, rd);
    check_word("even byte read", {8'h00, b0}, rd);
    host_write(`DBG_MEM_ADDR, 16'h0021);
    mem_access(16'h1 << `DBG_MEM_BYTE);
    host_read(`DBG_MEM_DATA, rd);
    check_word("odd byte read", {8'h00, b1}, rd);
    end_test();

    start_test("cpu_reg");
    data      = 16'($random(seed));
    en_before = mem_en_count;
    host_write(`DBG_MEM_ADDR, 16'h0005);
    host_write(`DBG_MEM_DATA, data);
    mem_access((16'h1 << `DBG_MEM_REG) | (16'h1 << `DBG_MEM_WRITE));
    check_word("model register", data, cpu0.regs[5]);
    host_write(`DBG_MEM_DATA, ~data);
    mem_access(16'h1 << `DBG_MEM_REG);
    host_read(`DBG_MEM_DATA, rd);
    check_word("register read back", data, rd);
    check_word("mem_en cycles", 16'h0, 16'(mem_en_count - en_before));
    end_test();

    $display("summary: %0d passed, %0d failed, %0d checks, %0d errors",
             passed, failed, checks, errors + hs_errors);
    if (failed == 0 && errors + hs_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/dbg_cpu_model.sv
/*
 * Behavioral CPU for the debug unit testbench
 * Halt status follows the halt command one cycle late,
 * 64-word memory with byte enables, 16 CPU registers
 */
`timescale 1ns/1ns

module dbg_cpu_model import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      dbg_halt_cmd,
  output logic      dbg_halt_st,
  input  dbg_word_t dbg_mem_addr,  // Byte address
  input  dbg_word_t dbg_mem_dout,
  input  logic      dbg_mem_en,
  input  mem_wr_t   dbg_mem_wr,
  input  logic      dbg_reg_wr,
  output dbg_word_t dbg_mem_din,
  output dbg_word_t dbg_reg_din
);

  dbg_word_t  mem [64];   // Word index is addr[6:1]
  dbg_word_t  regs [16];
  logic [5:0] widx;

  assign widx        = dbg_mem_addr[6:1];
  assign dbg_reg_din = regs[dbg_mem_addr[3:0]];  // Register file answers at once

  // Fill depends on the whole index
  initial begin
    for (int i = 0; i < 64; i++) mem[i] = 16'(i * 1027) ^ 16'hC3A0;
    for (int i = 0; i < 16; i++) regs[i] = 16'(i * 4369) ^ 16'h5A00;
  end

  always @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      dbg_halt_st <= 1'b0;
      dbg_mem_din <= 16'h0000;
    end else begin
      dbg_halt_st <= dbg_halt_cmd;                  // Core stops a cycle after the command
      if (dbg_mem_en) dbg_mem_din <= mem[widx];     // Read data one cycle late
    end
  end

  always @(posedge dbg_clk) begin
    if (dbg_mem_en && dbg_mem_wr[0]) mem[widx][7:0]  <= dbg_mem_dout[7:0];
    if (dbg_mem_en && dbg_mem_wr[1]) mem[widx][15:8] <= dbg_mem_dout[15:8];
    if (dbg_reg_wr) regs[dbg_mem_addr[3:0]] <= dbg_mem_dout;
  end

endmodule

// File: design/dbg_unit.sv
/*
 * Debug unit top
 * Host register port, register file, CPU run control and memory sequencer
 */
`timescale 1ns/1ns

module dbg_unit import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  // Host port
  input  logic      host_req,
  input  logic      host_wr,
  input  dbg_addr_t host_addr,
  input  dbg_word_t host_wdata,
  output logic      host_ack,
  output dbg_word_t host_rdata,
  // CPU status
  input  cpu_id_t   cpu_id,
  input  logic      dbg_halt_st,
  input  logic      cpu_en_s,
  input  logic      dbg_en_s,
  input  logic      puc_pnd_set,
  input  logic      decode_noirq,
  input  dbg_word_t fe_mdb_in,
  input  dbg_word_t dbg_mem_din,
  input  dbg_word_t dbg_reg_din,
  // CPU control and debug bus
  output logic      dbg_halt_cmd,
  output logic      dbg_freeze,
  output logic      dbg_cpu_reset,
  output dbg_word_t dbg_mem_addr,
  output dbg_word_t dbg_mem_dout,
  output logic      dbg_mem_en,
  output mem_wr_t   dbg_mem_wr,
  output logic      dbg_reg_wr
);

  dbg_addr_t reg_addr;
  dbg_word_t reg_wdata, reg_dout, cpu_ctl_rd, cpu_stat_rd;
  dbg_word_t mem_addr, mem_data, rd_data;
  logic      reg_wr, reg_rd, cpu_ctl_wr, cpu_stat_wr;
  logic      mem_start, mem_write, mem_reg, mem_byte;
  logic      rd_capture, mem_busy, mem_halt_cpu, mem_run_cpu;

  dbg_host_port u_host_port (
    .dbg_clk, .dbg_rst, .host_req, .host_wr, .host_addr, .host_wdata,
    .host_ack, .host_rdata, .reg_addr, .reg_wdata, .reg_wr, .reg_rd, .reg_dout
  );

  dbg_reg_file u_reg_file (
    .dbg_clk, .dbg_rst, .reg_addr, .reg_wdata, .reg_wr, .reg_rd, .reg_dout,
    .cpu_id, .cpu_ctl_wr, .cpu_stat_wr, .cpu_ctl_rd, .cpu_stat_rd,
    .mem_start, .mem_write, .mem_reg, .mem_byte, .mem_addr, .mem_data,
    .rd_capture, .rd_data, .mem_busy
  );

  dbg_cpu_ctl u_cpu_ctl (
    .dbg_clk, .dbg_rst, .cpu_ctl_wr, .cpu_stat_wr,
    .wdata        (reg_wdata),
    .cpu_ctl_rd, .cpu_stat_rd, .dbg_halt_st, .cpu_en_s, .dbg_en_s,
    .puc_pnd_set, .decode_noirq, .fe_mdb_in, .mem_halt_cpu, .mem_run_cpu,
    .dbg_halt_cmd, .dbg_freeze, .dbg_cpu_reset
  );

  dbg_mem_seq u_mem_seq (
    .dbg_clk, .dbg_rst, .mem_start, .mem_write, .mem_reg, .mem_byte,
    .mem_addr, .mem_data, .dbg_halt_st, .mem_halt_cpu, .mem_run_cpu,
    .mem_busy, .rd_capture, .rd_data, .dbg_mem_addr, .dbg_mem_dout,
    .dbg_mem_en, .dbg_mem_wr, .dbg_reg_wr, .dbg_mem_din, .dbg_reg_din
  );

endmodule

// File: design/dbg_mem_seq.sv
/*
 * Debug memory sequencer
 * Halts the CPU if needed, does one memory or CPU register access, resumes
 */
`timescale 1ns/1ns

module dbg_mem_seq import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      mem_start,
  input  logic      mem_write,
  input  logic      mem_reg,
  input  logic      mem_byte,
  input  dbg_word_t mem_addr,
  input  dbg_word_t mem_data,
  input  logic      dbg_halt_st,
  output logic      mem_halt_cpu,
  output logic      mem_run_cpu,
  output logic      mem_busy,
  output logic      rd_capture,
  output dbg_word_t rd_data,
  output dbg_word_t dbg_mem_addr,
  output dbg_word_t dbg_mem_dout,
  output logic      dbg_mem_en,
  output mem_wr_t   dbg_mem_wr,
  output logic      dbg_reg_wr,
  input  dbg_word_t dbg_mem_din,
  input  dbg_word_t dbg_reg_din
);

  mem_state_t state, state_nxt;
  logic       access;
  logic       reg_rd, mem_rd, mem_rd_dly;
  mem_wr_t    wr_msk;

  always_comb begin
    case (state)
      M_IDLE:       state_nxt = !mem_start ? M_IDLE : dbg_halt_st ? M_ACCESS : M_SET_BRK;
      M_SET_BRK:    state_nxt = dbg_halt_st ? M_ACCESS_BRK : M_SET_BRK;  // Wait for halt
      M_ACCESS_BRK: state_nxt = M_IDLE;
      M_ACCESS:     state_nxt = M_IDLE;
      default:      state_nxt = M_IDLE;
    endcase
  end

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      state      <= M_IDLE;
      mem_rd_dly <= 1'b0;
    end else begin
      state      <= state_nxt;
      mem_rd_dly <= mem_rd;  // Memory answers a cycle late
    end
  end

  assign mem_halt_cpu = (state == M_IDLE) && (state_nxt == M_SET_BRK);
  assign mem_run_cpu  = (state == M_ACCESS_BRK);  // Resume only if we halted it
  assign access       = (state == M_ACCESS) || (state == M_ACCESS_BRK);
  assign mem_busy     = mem_start | (state != M_IDLE) | mem_rd_dly;

  // Bus strobes
  assign dbg_reg_wr = access & mem_reg & mem_write;
  assign reg_rd     = access & mem_reg & ~mem_write;
  assign dbg_mem_en = access & ~mem_reg;
  assign mem_rd     = dbg_mem_en & ~mem_write;

  // Byte lane from address bit 0
  assign wr_msk       = !mem_byte ? 2'b11 : mem_addr[0] ? 2'b10 : 2'b01;
  assign dbg_mem_wr   = {2{dbg_mem_en & mem_write}} & wr_msk;
  assign dbg_mem_addr = mem_addr;
  assign dbg_mem_dout = !mem_byte   ? mem_data :
                        mem_addr[0] ? {mem_data[7:0], 8'h00} : {8'h00, mem_data[7:0]};

  // Read return, byte moved to low lane
  assign rd_capture = reg_rd | mem_rd_dly;
  assign rd_data    = !mem_rd_dly  ? dbg_reg_din :
                      !mem_byte    ? dbg_mem_din :
                      mem_addr[0]  ? {8'h00, dbg_mem_din[15:8]} : {8'h00, dbg_mem_din[7:0]};

endmodule

// File: design/dbg_cpu_ctl.sv
/*
 * CPU run control
 * CPU_CTL / CPU_STAT, halt flag, single step, software break, freeze, reset
 */
`timescale 1ns/1ns
`include "dbg_params.svh"

module dbg_cpu_ctl import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      cpu_ctl_wr,
  input  logic      cpu_stat_wr,
  input  dbg_word_t wdata,
  output dbg_word_t cpu_ctl_rd,
  output dbg_word_t cpu_stat_rd,
  input  logic      dbg_halt_st,   // CPU reports halted
  input  logic      cpu_en_s,
  input  logic      dbg_en_s,
  input  logic      puc_pnd_set,
  input  logic      decode_noirq,  // Instruction decode cycle
  input  dbg_word_t fe_mdb_in,     // Fetched opcode
  input  logic      mem_halt_cpu,
  input  logic      mem_run_cpu,
  output logic      dbg_halt_cmd,
  output logic      dbg_freeze,
  output logic      dbg_cpu_reset
);

  logic [6:3] cpu_ctl;   // Enable bits only, 2:0 are commands
  logic [3:2] cpu_stat;  // Sticky pending bits
  logic [1:0] inc_step;  // Step mask shifter
  logic       halt_flag;
  logic       halt_cpu, run_cpu, istep, halt_rst, swbrk, halt_set;

  // Commands only act in the matching run state
  assign halt_cpu = cpu_ctl_wr & wdata[`DBG_HALT]  & ~dbg_halt_st;
  assign run_cpu  = cpu_ctl_wr & wdata[`DBG_RUN]   &  dbg_halt_st;
  assign istep    = cpu_ctl_wr & wdata[`DBG_ISTEP] &  dbg_halt_st;

  assign swbrk    = (fe_mdb_in == `DBG_SWBRK_OP) & decode_noirq & cpu_ctl[`DBG_SW_BRK_EN];
  assign halt_rst = cpu_ctl[`DBG_RST_BRK_EN] & dbg_en_s & puc_pnd_set;  // Break after reset
  assign halt_set = halt_cpu | halt_rst | swbrk | mem_halt_cpu;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      cpu_ctl   <= `DBG_CPU_CTL_RST;
      cpu_stat  <= 2'b00;
      inc_step  <= 2'b00;
      halt_flag <= 1'b0;
    end else begin
      if (cpu_ctl_wr) begin
        cpu_ctl <= wdata[6:3];
      end
      // Write 1 clears, a new event wins
      cpu_stat <= (cpu_stat & ~(wdata[3:2] & {2{cpu_stat_wr}})) | {swbrk, puc_pnd_set};
      inc_step <= istep ? 2'b11 : {inc_step[0], 1'b0};
      if (run_cpu | mem_run_cpu) begin
        halt_flag <= 1'b0;
      end else if (halt_set) begin
        halt_flag <= 1'b1;
      end
    end
  end

  assign dbg_halt_cmd  = (halt_flag | halt_set) & ~inc_step[1];  // Released 2 cycles on step
  assign dbg_freeze    = dbg_halt_st & (cpu_ctl[`DBG_FRZ_BRK_EN] | ~cpu_en_s);
  assign dbg_cpu_reset = cpu_ctl[`DBG_CPU_RST];

  assign cpu_ctl_rd  = {9'h000, cpu_ctl, 3'b000};
  assign cpu_stat_rd = {12'h000, cpu_stat, 1'b0, dbg_halt_st};

endmodule

// File: design/dbg_reg_file.sv
/*
 * Debug register file
 * Address decode, MEM_CTL / MEM_ADDR / MEM_DATA and the read-back mux
 */
`timescale 1ns/1ns
`include "dbg_params.svh"

module dbg_reg_file import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  dbg_addr_t reg_addr,
  input  dbg_word_t reg_wdata,
  input  logic      reg_wr,
  input  logic      reg_rd,
  output dbg_word_t reg_dout,
  input  cpu_id_t   cpu_id,
  output logic      cpu_ctl_wr,
  output logic      cpu_stat_wr,
  input  dbg_word_t cpu_ctl_rd,   // Unmasked CPU_CTL view
  input  dbg_word_t cpu_stat_rd,  // Unmasked CPU_STAT view
  output logic      mem_start,
  output logic      mem_write,
  output logic      mem_reg,
  output logic      mem_byte,
  output dbg_word_t mem_addr,
  output dbg_word_t mem_data,
  input  logic      rd_capture,   // Load MEM_DATA from rd_data
  input  dbg_word_t rd_data,
  input  logic      mem_busy
);

  //////////////////////////////
  // Decode
  //////////////////////////////
  logic [6:0] reg_sel;  // One-hot by address
  logic [6:0] wr_sel;
  logic [6:0] rd_sel;
  logic [3:1] mem_ctl;  // BYTE, REG, WRITE

  assign reg_sel[0] = (reg_addr == `DBG_CPU_ID_LO);
  assign reg_sel[1] = (reg_addr == `DBG_CPU_ID_HI);
  assign reg_sel[2] = (reg_addr == `DBG_CPU_CTL);
  assign reg_sel[3] = (reg_addr == `DBG_CPU_STAT);
  assign reg_sel[4] = (reg_addr == `DBG_MEM_CTL);
  assign reg_sel[5] = (reg_addr == `DBG_MEM_ADDR);
  assign reg_sel[6] = (reg_addr == `DBG_MEM_DATA);

  assign wr_sel = reg_sel & {7{reg_wr}};
  assign rd_sel = reg_sel & {7{reg_rd}};

  assign cpu_ctl_wr  = wr_sel[2];
  assign cpu_stat_wr = wr_sel[3];

  //////////////////////////////
  // Memory access registers
  //////////////////////////////
  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      mem_ctl   <= 3'b000;
      mem_start <= 1'b0;
    end else begin
      if (wr_sel[4]) begin
        mem_ctl <= reg_wdata[`DBG_MEM_BYTE:`DBG_MEM_WRITE];
      end
      mem_start <= wr_sel[4] & reg_wdata[`DBG_MEM_START];  // Start bit is not stored
    end
  end

  assign mem_write = mem_ctl[`DBG_MEM_WRITE];
  assign mem_reg   = mem_ctl[`DBG_MEM_REG];
  assign mem_byte  = mem_ctl[`DBG_MEM_BYTE];

  always_ff @(posedge dbg_clk) begin
    if (wr_sel[5]) begin
      mem_addr <= reg_wdata;
    end
    // Host write wins over a returning read
    if (wr_sel[6]) begin
      mem_data <= reg_wdata;
    end else if (rd_capture) begin
      mem_data <= rd_data;
    end
  end

  //////////////////////////////
  // Read-back
  //////////////////////////////
  assign reg_dout = (cpu_id[15:0]                  & {16{rd_sel[0]}})
                  | (cpu_id[31:16]                 & {16{rd_sel[1]}})
                  | (cpu_ctl_rd                    & {16{rd_sel[2]}})
                  | (cpu_stat_rd                   & {16{rd_sel[3]}})
                  | ({12'h000, mem_ctl, mem_busy}  & {16{rd_sel[4]}})  // Bit 0 is busy
                  | (mem_addr                      & {16{rd_sel[5]}})
                  | (mem_data                      & {16{rd_sel[6]}});

endmodule

// File: design/dbg_host_port.sv
/*
 * Debug host port
 * Four-phase req/ack front end, one register access per handshake
 */
`timescale 1ns/1ns

module dbg_host_port import dbg_pkg::*; (
  input  logic      dbg_clk,
  input  logic      dbg_rst,
  input  logic      host_req,    // Held high until ack seen
  input  logic      host_wr,     // 1 write, 0 read
  input  dbg_addr_t host_addr,
  input  dbg_word_t host_wdata,
  output logic      host_ack,
  output dbg_word_t host_rdata,
  output dbg_addr_t reg_addr,
  output dbg_word_t reg_wdata,
  output logic      reg_wr,      // Single-cycle write strobe
  output logic      reg_rd,      // Single-cycle read strobe
  input  dbg_word_t reg_dout
);

  logic req_q;    // Sampled request
  logic acc_stb;  // One access per rising req

  // Fires once, ack blocks repeat until req drops
  assign acc_stb = req_q & ~host_ack;

  always_ff @(posedge dbg_clk or posedge dbg_rst) begin
    if (dbg_rst) begin
      req_q    <= 1'b0;
      host_ack <= 1'b0;
    end else begin
      req_q    <= host_req;
      host_ack <= acc_stb | (host_ack & host_req);  // Falls once req sampled low
    end
  end

  // Read-back word, held through ack
  always_ff @(posedge dbg_clk) begin
    if (acc_stb) begin
      host_rdata <= reg_dout;
    end
  end

  // Host holds addr and data steady during req
  assign reg_addr  = host_addr;
  assign reg_wdata = host_wdata;
  assign reg_wr    = acc_stb & host_wr;
  assign reg_rd    = acc_stb & ~host_wr;

endmodule

// File: design/dbg_pkg.sv
/*
 * Debug unit types
 * Width typedefs and the memory access FSM encoding
 */
package dbg_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////
  typedef logic [5:0]  dbg_addr_t;  // Debug register address
  typedef logic [15:0] dbg_word_t;  // Debug data word
  typedef logic [31:0] cpu_id_t;    // CPU identification
  typedef logic [1:0]  mem_wr_t;    // Byte write enables

  //////////////////////////////
  // Memory access FSM
  //////////////////////////////
  typedef enum logic [1:0] {
    M_IDLE       = 2'd0,  // Waiting for start
    M_SET_BRK    = 2'd1,  // Halting a running CPU
    M_ACCESS_BRK = 2'd2,  // Access, then restart CPU
    M_ACCESS     = 2'd3   // Access, CPU already halted
  } mem_state_t;

endpackage

// File: design/dbg_params.svh
/*
 * Debug unit constants
 * Register map, CPU_CTL / CPU_STAT / MEM_CTL bit positions, break opcode
 */
`ifndef DBG_PARAMS_SVH
`define DBG_PARAMS_SVH

// Register addresses
`define DBG_CPU_ID_LO   6'd0
`define DBG_CPU_ID_HI   6'd1
`define DBG_CPU_CTL     6'd2
`define DBG_CPU_STAT    6'd3
`define DBG_MEM_CTL     6'd4
`define DBG_MEM_ADDR    6'd5
`define DBG_MEM_DATA    6'd6

// CPU_CTL bits
`define DBG_HALT        0
`define DBG_RUN         1
`define DBG_ISTEP       2
`define DBG_SW_BRK_EN   3
`define DBG_FRZ_BRK_EN  4
`define DBG_RST_BRK_EN  5
`define DBG_CPU_RST     6

// CPU_STAT sticky bits
`define DBG_STAT_PUC_PND    2
`define DBG_STAT_SWBRK_PND  3

// MEM_CTL bits
`define DBG_MEM_START   0
`define DBG_MEM_WRITE   1
`define DBG_MEM_REG     2
`define DBG_MEM_BYTE    3

`define DBG_SWBRK_OP    16'h4343  // Software break opcode
`define DBG_CPU_CTL_RST 4'h2      // CPU_CTL[6:3] after reset, freeze on break

`endif
